//--- rtl/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

	//--------------------------------------------------------------------
	// Wishbone classic
	//--------------------------------------------------------------------
	// Byte addressed, 32-bit data
	localparam int unsigned WB_ADR_W = 32;
	localparam int unsigned WB_DAT_W = 32;
	// One select per byte lane
	localparam int unsigned WB_SEL_W = WB_DAT_W / 8;

	//--------------------------------------------------------------------
	// CSR bus
	//--------------------------------------------------------------------
	// Word address, bank number in the top five bits
	localparam int unsigned CSR_ADR_W = 15;
	localparam int unsigned CSR_BANK_LSB = 10;

	typedef logic [WB_ADR_W-1:0] wb_adr_t;
	typedef logic [WB_DAT_W-1:0] wb_dat_t;
	typedef logic [WB_SEL_W-1:0] wb_sel_t;
	typedef logic [CSR_ADR_W-1:0] csr_adr_t;

endpackage

`default_nettype wire

//--- rtl/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

	//--------------------------------------------------------------------
	// Wishbone address map
	//--------------------------------------------------------------------
	// Decode on bits 30..28, bit 31 only mirrors
	localparam int unsigned ADR_DEC_LSB = 28;
	// Debug RAM at 0x10000000
	localparam logic [2:0] DEBUG_RAM_SEL = 3'b001;
	// CSR bridge at 0x60000000, bits 30..29 only
	localparam logic [1:0] CSR_SEL = 2'b11;
	localparam int unsigned RAM_WORDS = 256;

	//--------------------------------------------------------------------
	// System controller
	//--------------------------------------------------------------------
	typedef logic [soc_bus_pkg::CSR_BANK_LSB-1:0] reg_ofs_t;

	localparam logic [soc_bus_pkg::CSR_ADR_W-soc_bus_pkg::CSR_BANK_LSB-1:0] SYSCTL_BANK = 'd1;
	localparam reg_ofs_t REG_GPIO_IN = 'd0;
	localparam reg_ofs_t REG_GPIO_OUT = 'd1;
	localparam reg_ofs_t REG_TIMER_CTRL = 'd2;
	localparam reg_ofs_t REG_TIMER_COMPARE = 'd3;
	localparam reg_ofs_t REG_TIMER_COUNTER = 'd4;
	localparam reg_ofs_t REG_SYSTEM_ID = 'd5;
	localparam reg_ofs_t REG_HARD_RESET = 'd6;
	// Board ID, 1.2.0 final
	localparam soc_bus_pkg::wb_dat_t SYSTEM_ID = 32'h12004D31;

	// Reset timing, system reset outlasts the flash reset
	localparam int unsigned RST_HOLD_CYCLES = 256;
	localparam int unsigned FLASH_RST_CYCLES = 128;

	// 3 buttons + 4 revision bits in, 2 LEDs out
	localparam int unsigned GPIO_IN_W = 7;
	localparam int unsigned GPIO_OUT_W = 2;

endpackage

`default_nettype wire

//--- rtl/soc_ifs.sv
`timescale 1ns/1ps
`default_nettype none

//----------------------------------------------------------------------
// Wishbone classic, single master to single slave
//----------------------------------------------------------------------
interface wb_if ();
	import soc_bus_pkg::*;

	wb_adr_t adr;
	wb_dat_t dat_w;
	wb_dat_t dat_r;
	wb_sel_t sel;
	logic we;
	logic cyc;
	logic stb;
	logic ack;

	// Request side
	modport master (
		output adr, dat_w, sel, we, cyc, stb,
		input dat_r, ack
	);

	// Response side
	modport slave (
		input adr, dat_w, sel, we, cyc, stb,
		output dat_r, ack
	);
endinterface

//----------------------------------------------------------------------
// CSR bus, shared by all banks
//----------------------------------------------------------------------
interface csr_if ();
	import soc_bus_pkg::*;

	csr_adr_t a;
	logic we;
	wb_dat_t dw;
	wb_dat_t dr;

	modport master (output a, we, dw, input dr);
	// Peripheral returns zero when not addressed
	modport slave (input a, we, dw, output dr);
endinterface

`default_nettype wire

//--- rtl/reset_gen.sv
`timescale 1ns/1ps
`default_nettype none

module reset_gen (
	input wire sys_clk,
	input wire trigger_reset,
	input wire [2:0] btn_i,
	input wire hard_reset_i,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);
	import soc_map_pkg::*;

	typedef logic [$clog2(RST_HOLD_CYCLES+1)-1:0] hold_cnt_t;
	typedef logic [$clog2(FLASH_RST_CYCLES+1)-1:0] flash_cnt_t;

	logic trig_q;
	hold_cnt_t hold_cnt;
	flash_cnt_t flash_cnt;

	// Combined trigger, all three buttons act as reset button
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			trig_q <= 1'b1;
			hold_cnt <= hold_cnt_t'(RST_HOLD_CYCLES);
			flash_cnt <= '0;
		end else begin
			trig_q <= (&btn_i) | hard_reset_i;
			// Hold counter reloads while any trigger present
			if (trig_q) begin
				hold_cnt <= hold_cnt_t'(RST_HOLD_CYCLES);
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
			// Flash wakes up before the rest of the system
			if (trig_q) begin
				flash_cnt <= '0;
			end else if (flash_cnt != flash_cnt_t'(FLASH_RST_CYCLES)) begin
				flash_cnt <= flash_cnt + 1'b1;
			end
		end
	end

	assign sys_rst_o = (hold_cnt != '0);
	assign flash_rst_n_o = (flash_cnt == flash_cnt_t'(FLASH_RST_CYCLES));

endmodule

`default_nettype wire

//--- rtl/wb_switch.sv
`timescale 1ns/1ps
`default_nettype none

module wb_switch (
	input wire sys_clk,
	input wire sys_rst,
	wb_if.slave m,
	wb_if.master s_ram,
	wb_if.master s_csr
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic sel_ram;
	logic sel_csr;
	logic sel_none;
	logic nomap_ack;

	//--------------------------------------------------------------------
	// Address decode
	//--------------------------------------------------------------------
	// Bit 31 skipped, upper half is a shadow
	assign sel_ram = (m.adr[WB_ADR_W-2:ADR_DEC_LSB] == DEBUG_RAM_SEL);
	assign sel_csr = (m.adr[WB_ADR_W-2:ADR_DEC_LSB+1] == CSR_SEL);
	assign sel_none = ~sel_ram & ~sel_csr;

	// Request fan-out, strobes gated per slave
	assign s_ram.adr = m.adr;
	assign s_ram.dat_w = m.dat_w;
	assign s_ram.sel = m.sel;
	assign s_ram.we = m.we;
	assign s_ram.cyc = m.cyc & sel_ram;
	assign s_ram.stb = m.stb & sel_ram;

	assign s_csr.adr = m.adr;
	assign s_csr.dat_w = m.dat_w;
	assign s_csr.sel = m.sel;
	assign s_csr.we = m.we;
	assign s_csr.cyc = m.cyc & sel_csr;
	assign s_csr.stb = m.stb & sel_csr;

	// Unmapped hole, ack locally so the master never hangs
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			nomap_ack <= 1'b0;
		end else begin
			nomap_ack <= m.cyc & m.stb & sel_none & ~nomap_ack;
		end
	end

	//--------------------------------------------------------------------
	// Response return
	//--------------------------------------------------------------------
	always_comb begin
		m.dat_r = '0;
		if (sel_ram) begin
			m.dat_r = s_ram.dat_r;
		end else if (sel_csr) begin
			m.dat_r = s_csr.dat_r;
		end
	end

	assign m.ack = (sel_ram & s_ram.ack) | (sel_csr & s_csr.ack) | nomap_ack;

endmodule

`default_nettype wire

//--- rtl/wb_ram.sv
`timescale 1ns/1ps
`default_nettype none

module wb_ram (
	input wire sys_clk,
	input wire sys_rst,
	wb_if.slave bus
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	typedef logic [$clog2(RAM_WORDS)-1:0] ram_idx_t;

	wb_dat_t mem [0:RAM_WORDS-1];
	wb_dat_t dat_q;
	ram_idx_t idx;
	logic ack_q;
	logic start;

	// Word index from address bits 9..2
	assign idx = bus.adr[$clog2(RAM_WORDS)+1:2];
	// New access, not the ack cycle of the last one
	assign start = bus.cyc & bus.stb & ~ack_q & ~sys_rst;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= start;
		end
	end

	// Read data and byte writes land together with ack
	always_ff @(posedge sys_clk) begin
		if (start) begin
			dat_q <= mem[idx];
			if (bus.we) begin
				for (int i = 0; i < WB_SEL_W; i++) begin
					if (bus.sel[i]) begin
						mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
					end
				end
			end
		end
	end

	assign bus.dat_r = dat_q;
	assign bus.ack = ack_q;

endmodule

`default_nettype wire

//--- rtl/csr_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module csr_bridge (
	input wire sys_clk,
	input wire sys_rst,
	wb_if.slave wb,
	csr_if.master csr
);
	import soc_bus_pkg::*;

	// Idle, CSR access, Wishbone ack
	typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_ACK} state_t;

	state_t state;
	csr_adr_t a_q;
	wb_dat_t dw_q;
	wb_dat_t dr_q;
	logic we_q;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= ST_IDLE;
			we_q <= 1'b0;
		end else begin
			// Write strobe lasts one cycle only
			we_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (wb.cyc & wb.stb) begin
						state <= ST_ACCESS;
						we_q <= wb.we;
					end
				end
				ST_ACCESS: state <= ST_ACK;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Address and data captured at the start
	always_ff @(posedge sys_clk) begin
		if (state == ST_IDLE) begin
			a_q <= wb.adr[CSR_ADR_W+1:2];
			dw_q <= wb.dat_w;
		end
		// dr is already the OR of all banks, empty banks give zero
		if (state == ST_ACCESS) begin
			dr_q <= csr.dr;
		end
	end

	assign csr.a = a_q;
	assign csr.we = we_q;
	assign csr.dw = dw_q;
	assign wb.dat_r = dr_q;
	assign wb.ack = (state == ST_ACK);

endmodule

`default_nettype wire

//--- rtl/sysctl.sv
`timescale 1ns/1ps
`default_nettype none

module sysctl (
	input wire sys_clk,
	input wire sys_rst,
	csr_if.slave csr,
	input wire [soc_map_pkg::GPIO_IN_W-1:0] gpio_in_i,
	output logic [soc_map_pkg::GPIO_OUT_W-1:0] led_o,
	output logic gpio_irq_o,
	output logic timer_irq_o,
	output logic hard_reset_o
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic [GPIO_IN_W-1:0] gpio_meta;
	logic [GPIO_IN_W-1:0] gpio_sync;
	logic [GPIO_IN_W-1:0] gpio_last;
	logic bank_sel;
	logic wr;
	reg_ofs_t ofs;
	logic tmr_en;
	logic tmr_ar;
	logic tmr_match;
	wb_dat_t tmr_compare;
	wb_dat_t tmr_counter;

	assign bank_sel = (csr.a[CSR_ADR_W-1:CSR_BANK_LSB] == SYSCTL_BANK);
	assign ofs = csr.a[CSR_BANK_LSB-1:0];
	assign wr = csr.we & bank_sel;
	assign tmr_match = tmr_en & (tmr_counter == tmr_compare);

	// Two-flop sync, third stage for edge detection
	always_ff @(posedge sys_clk) begin
		gpio_meta <= gpio_in_i;
		gpio_sync <= gpio_meta;
		gpio_last <= gpio_sync;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			gpio_irq_o <= 1'b0;
			timer_irq_o <= 1'b0;
			hard_reset_o <= 1'b0;
			led_o <= '0;
			tmr_en <= 1'b0;
			tmr_ar <= 1'b0;
			tmr_compare <= '0;
			tmr_counter <= '0;
		end else begin
			gpio_irq_o <= (gpio_sync != gpio_last);
			timer_irq_o <= tmr_match;
			hard_reset_o <= wr & (ofs == REG_HARD_RESET);
			// Timer, one-shot unless autorestart
			if (tmr_match) begin
				tmr_counter <= '0;
				tmr_en <= tmr_ar;
			end else if (tmr_en) begin
				tmr_counter <= tmr_counter + 1'b1;
			end
			// CSR writes win over the timer
			if (wr) begin
				case (ofs)
					REG_GPIO_OUT: led_o <= csr.dw[GPIO_OUT_W-1:0];
					REG_TIMER_CTRL: begin
						tmr_en <= csr.dw[0];
						tmr_ar <= csr.dw[1];
					end
					REG_TIMER_COMPARE: tmr_compare <= csr.dw;
					REG_TIMER_COUNTER: tmr_counter <= csr.dw;
					default: ;
				endcase
			end
		end
	end

	// Reads, zero outside bank 1
	always_comb begin
		csr.dr = '0;
		if (bank_sel) begin
			case (ofs)
				REG_GPIO_IN: csr.dr = wb_dat_t'(gpio_sync);
				REG_GPIO_OUT: csr.dr = wb_dat_t'(led_o);
				REG_TIMER_CTRL: csr.dr = wb_dat_t'({tmr_ar, tmr_en});
				REG_TIMER_COMPARE: csr.dr = tmr_compare;
				REG_TIMER_COUNTER: csr.dr = tmr_counter;
				REG_SYSTEM_ID: csr.dr = SYSTEM_ID;
				default: csr.dr = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/soc_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module soc_fabric (
	input wire sys_clk,
	input wire trigger_reset,
	input wire soc_bus_pkg::wb_adr_t wb_adr_i,
	input wire soc_bus_pkg::wb_dat_t wb_dat_i,
	input wire soc_bus_pkg::wb_sel_t wb_sel_i,
	input wire wb_we_i,
	input wire wb_cyc_i,
	input wire wb_stb_i,
	output soc_bus_pkg::wb_dat_t wb_dat_o,
	output logic wb_ack_o,
	input wire [2:0] btn_i,
	input wire [3:0] pcb_revision_i,
	output logic [soc_map_pkg::GPIO_OUT_W-1:0] led_o,
	output logic gpio_irq_o,
	output logic timer_irq_o,
	output logic flash_rst_n_o,
	output logic periph_rst_n_o
);
	import soc_map_pkg::*;

	logic sys_rst;
	logic hard_reset;
	logic [GPIO_IN_W-1:0] gpio_in;

	wb_if wb_m ();
	wb_if wb_ram_bus ();
	wb_if wb_csr_bus ();
	csr_if csr_bus ();

	//--------------------------------------------------------------------
	// Reset
	//--------------------------------------------------------------------
	reset_gen u_reset_gen (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.btn_i(btn_i),
		.hard_reset_i(hard_reset),
		.sys_rst_o(sys_rst),
		.flash_rst_n_o(flash_rst_n_o)
	);

	assign periph_rst_n_o = ~sys_rst;

	//--------------------------------------------------------------------
	// Wishbone
	//--------------------------------------------------------------------
	// External master port
	assign wb_m.adr = wb_adr_i;
	assign wb_m.dat_w = wb_dat_i;
	assign wb_m.sel = wb_sel_i;
	assign wb_m.we = wb_we_i;
	assign wb_m.cyc = wb_cyc_i;
	assign wb_m.stb = wb_stb_i;
	assign wb_dat_o = wb_m.dat_r;
	assign wb_ack_o = wb_m.ack;

	wb_switch u_wb_switch (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.m(wb_m),
		.s_ram(wb_ram_bus),
		.s_csr(wb_csr_bus)
	);

	// Debug scratch RAM, 0x10000000
	wb_ram u_wb_ram (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.bus(wb_ram_bus)
	);

	// CSR space, 0x60000000
	csr_bridge u_csr_bridge (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.wb(wb_csr_bus),
		.csr(csr_bus)
	);

	//--------------------------------------------------------------------
	// System controller, bank 1
	//--------------------------------------------------------------------
	assign gpio_in = {pcb_revision_i, btn_i};

	sysctl u_sysctl (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr(csr_bus),
		.gpio_in_i(gpio_in),
		.led_o(led_o),
		.gpio_irq_o(gpio_irq_o),
		.timer_irq_o(timer_irq_o),
		.hard_reset_o(hard_reset)
	);

endmodule

`default_nettype wire

//--- test/soc_fabric_checker.sv
`timescale 1ns/1ps
`default_nettype none

module soc_fabric_checker (
	input wire sys_clk,
	input wire trigger_reset,
	input wire wb_cyc_i,
	input wire wb_stb_i,
	input wire wb_ack_i,
	input wire gpio_irq_i,
	input wire timer_irq_i,
	input wire flash_rst_n_i
);

	// Number of assertion failures so far
	int fail_count = 0;

	//--------------------------------------------------------------------
	// Wishbone handshake at the top level
	//--------------------------------------------------------------------
	ack_in_cycle: assert property (@(posedge sys_clk) disable iff (trigger_reset)
		wb_ack_i |-> (wb_cyc_i && wb_stb_i))
		else begin
			$error("wb_ack_o high without cyc and stb");
			fail_count++;
		end

	// Ack is a single-cycle pulse
	ack_single: assert property (@(posedge sys_clk) disable iff (trigger_reset)
		wb_ack_i |=> !wb_ack_i)
		else begin
			$error("wb_ack_o high in two consecutive cycles");
			fail_count++;
		end

	// Interrupts
	gpio_irq_single: assert property (@(posedge sys_clk) disable iff (trigger_reset)
		gpio_irq_i |=> !gpio_irq_i)
		else begin
			$error("gpio_irq_o longer than one cycle");
			fail_count++;
		end

	timer_irq_single: assert property (@(posedge sys_clk) disable iff (trigger_reset)
		timer_irq_i |=> !timer_irq_i)
		else begin
			$error("timer_irq_o longer than one cycle");
			fail_count++;
		end

	// Flash held in reset by the trigger
	flash_in_reset: assert property (@(posedge sys_clk)
		trigger_reset |=> !flash_rst_n_i)
		else begin
			$error("flash_rst_n_o high after trigger_reset");
			fail_count++;
		end

endmodule

bind soc_fabric soc_fabric_checker u_checker (
	.sys_clk(sys_clk),
	.trigger_reset(trigger_reset),
	.wb_cyc_i(wb_cyc_i),
	.wb_stb_i(wb_stb_i),
	.wb_ack_i(wb_ack_o),
	.gpio_irq_i(gpio_irq_o),
	.timer_irq_i(timer_irq_o),
	.flash_rst_n_i(flash_rst_n_o)
);

`default_nettype wire

//--- test/soc_fabric_tb.sv
`timescale 1ns/1ps
`default_nettype none

module soc_fabric_tb;
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	//--------------------------------------------------------------------
	// Run length and limits
	//--------------------------------------------------------------------
	localparam int CLK_PERIOD = 40;
	localparam int RESET_LEN = 10;
	localparam int N_RAM_OPS = 300;
	localparam int N_UNMAPPED = 40;
	localparam int N_GPIO = 12;
	localparam int TIMER_MAX = 200;
	// Slowest access, ack hold and idle gap included
	localparam int ACCESS_CYCLES = 6;
	localparam int BUS_TIMEOUT = 20;
	localparam int N_ACCESSES = 3 * RAM_WORDS + N_RAM_OPS + 4 * N_UNMAPPED
		+ N_GPIO + TIMER_MAX + 40;
	localparam int RESET_CYCLES = RESET_LEN + RST_HOLD_CYCLES + 20;
	// Four resets, GPIO hold time, then double it all
	localparam int WATCHDOG_CYCLES = 2 * (N_ACCESSES * ACCESS_CYCLES
		+ 4 * RESET_CYCLES + N_GPIO * 8);

	logic sys_clk;
	logic trigger_reset;
	wb_adr_t wb_adr;
	wb_dat_t wb_dat_w;
	wb_dat_t wb_dat_r;
	wb_sel_t wb_sel;
	logic wb_we;
	logic wb_cyc;
	logic wb_stb;
	logic wb_ack;
	logic [2:0] btn;
	logic [3:0] pcb_rev;
	logic [GPIO_OUT_W-1:0] led;
	logic gpio_irq;
	logic timer_irq;
	logic flash_rst_n;
	logic periph_rst_n;

	integer seed;
	int error_count = 0;
	int check_count = 0;
	int gpio_irq_count = 0;
	int timer_irq_count = 0;

	// Reference model
	wb_dat_t ram_model [0:RAM_WORDS-1];
	logic [GPIO_OUT_W-1:0] led_shadow;
	wb_dat_t compare_shadow;
	logic [1:0] ctrl_shadow;

	soc_fabric u_soc_fabric (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat_w),
		.wb_sel_i(wb_sel),
		.wb_we_i(wb_we),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.wb_dat_o(wb_dat_r),
		.wb_ack_o(wb_ack),
		.btn_i(btn),
		.pcb_revision_i(pcb_rev),
		.led_o(led),
		.gpio_irq_o(gpio_irq),
		.timer_irq_o(timer_irq),
		.flash_rst_n_o(flash_rst_n),
		.periph_rst_n_o(periph_rst_n)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	// Interrupt pulses, counted mid-cycle
	always @(negedge sys_clk) begin
		if (gpio_irq === 1'b1) begin
			gpio_irq_count++;
		end
		if (timer_irq === 1'b1) begin
			timer_irq_count++;
		end
	end

	//--------------------------------------------------------------------
	// Helpers
	//--------------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			$display("ERROR at %0d ns: %s expected 0x%08h, actual 0x%08h",
				$time, name, expected, actual);
			error_count++;
		end
	endtask

	// Sysctl register address in CSR space
	function automatic wb_adr_t csr_addr(input logic [4:0] bank, input reg_ofs_t ofs);
		return {3'b011, 12'd0, bank, ofs, 2'b00};
	endfunction

	// Never all three, that would reset the system
	function automatic logic [2:0] random_buttons();
		logic [2:0] b;
		b = $random(seed);
		if (b == 3'b111) begin
			b = 3'b011;
		end
		return b;
	endfunction

	// One classic cycle, request held through the ack edge
	task automatic bus_access(input wb_adr_t adr, input logic we, input wb_dat_t dat,
		input wb_sel_t sel, output wb_dat_t rdat);
		int waited;
		waited = 0;
		@(negedge sys_clk);
		wb_adr = adr;
		wb_dat_w = dat;
		wb_sel = sel;
		wb_we = we;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		do begin
			@(negedge sys_clk);
			waited++;
		end while (wb_ack !== 1'b1 && waited < BUS_TIMEOUT);
		rdat = wb_dat_r;
		if (wb_ack !== 1'b1) begin
			$display("Bus timeout: no ack for address 0x%08h within %0d cycles",
				adr, BUS_TIMEOUT);
			error_count++;
		end else begin
			@(negedge sys_clk);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic bus_write(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
		wb_dat_t unused;
		bus_access(adr, 1'b1, dat, sel, unused);
	endtask

	task automatic bus_read(input wb_adr_t adr, output wb_dat_t rdat);
		bus_access(adr, 1'b0, '0, '1, rdat);
	endtask

	task automatic wait_periph(input logic level, input int max_cycles, input string what);
		int waited;
		waited = 0;
		while (periph_rst_n !== level && waited < max_cycles) begin
			@(negedge sys_clk);
			waited++;
		end
		if (periph_rst_n !== level) begin
			$display("%s: periph_rst_n_o did not go to %0b within %0d cycles",
				what, level, max_cycles);
			error_count++;
		end
	endtask

	// Sysctl back at reset values
	task automatic check_reset_state();
		wb_dat_t rdat;
		led_shadow = '0;
		ctrl_shadow = 2'b00;
		compare_shadow = '0;
		check_value("led_o after reset", 32'(led_shadow), 32'(led));
		bus_read(csr_addr(SYSCTL_BANK, REG_TIMER_CTRL), rdat);
		check_value("timer control after reset", 32'(ctrl_shadow), rdat);
	endtask

	// Compare current sysctl state with the shadows
	task automatic check_sysctl_state();
		wb_dat_t rdat;
		check_value("led_o", 32'(led_shadow), 32'(led));
		bus_read(csr_addr(SYSCTL_BANK, REG_GPIO_OUT), rdat);
		check_value("GPIO output register", 32'(led_shadow), rdat);
		bus_read(csr_addr(SYSCTL_BANK, REG_TIMER_COMPARE), rdat);
		check_value("timer compare", compare_shadow, rdat);
		bus_read(csr_addr(SYSCTL_BANK, REG_TIMER_CTRL), rdat);
		check_value("timer control", 32'(ctrl_shadow), rdat);
	endtask

	// Trigger for RESET_LEN cycles, flash must come out first
	task automatic pulse_trigger_reset();
		int flash_rise;
		int periph_rise;
		@(negedge sys_clk);
		trigger_reset = 1'b1;
		repeat (RESET_LEN) @(negedge sys_clk);
		check_value("flash_rst_n_o during trigger", 32'd0, 32'(flash_rst_n));
		check_value("periph_rst_n_o during trigger", 32'd0, 32'(periph_rst_n));
		trigger_reset = 1'b0;
		flash_rise = -1;
		periph_rise = -1;
		for (int cycle = 0; cycle < RESET_CYCLES && periph_rise < 0; cycle++) begin
			@(negedge sys_clk);
			if (flash_rise < 0 && flash_rst_n === 1'b1) begin
				flash_rise = cycle;
			end
			if (periph_rst_n === 1'b1) begin
				periph_rise = cycle;
			end
		end
		if (periph_rise < 0) begin
			$display("periph_rst_n_o stayed low %0d cycles after the trigger", RESET_CYCLES);
			error_count++;
		end
		check_value("flash_rst_n_o rises before periph_rst_n_o", 32'd1,
			32'(flash_rise >= 0 && flash_rise < periph_rise));
	endtask

	//--------------------------------------------------------------------
	// Debug RAM
	//--------------------------------------------------------------------
	task automatic verify_ram();
		wb_adr_t adr;
		wb_dat_t rdat;
		for (int i = 0; i < RAM_WORDS; i++) begin
			adr = '0;
			adr[30:28] = DEBUG_RAM_SEL;
			adr[9:2] = i;
			// Odd words through the bit 31 mirror
			adr[31] = i[0];
			bus_read(adr, rdat);
			check_value("wb_dat_o (RAM verify)", ram_model[i], rdat);
		end
	endtask

	task automatic ram_test();
		wb_adr_t adr;
		wb_dat_t dat;
		wb_dat_t rdat;
		wb_sel_t sel;
		int idx;
		// Known contents first, so partial writes merge into defined data
		for (int i = 0; i < RAM_WORDS; i++) begin
			adr = '0;
			adr[30:28] = DEBUG_RAM_SEL;
			adr[9:2] = i;
			dat = $random(seed);
			ram_model[i] = dat;
			bus_write(adr, dat, '1);
		end
		for (int n = 0; n < N_RAM_OPS; n++) begin
			adr = $random(seed);
			adr[30:28] = DEBUG_RAM_SEL;
			adr[1:0] = 2'b00;
			idx = adr[9:2];
			if ($random(seed) & 1) begin
				dat = $random(seed);
				sel = $random(seed);
				for (int b = 0; b < WB_SEL_W; b++) begin
					if (sel[b]) begin
						ram_model[idx][8*b +: 8] = dat[8*b +: 8];
					end
				end
				bus_write(adr, dat, sel);
			end else begin
				bus_read(adr, rdat);
				check_value("wb_dat_o (RAM read)", ram_model[idx], rdat);
			end
		end
	endtask

	//--------------------------------------------------------------------
	// Holes and empty CSR banks
	//--------------------------------------------------------------------
	task automatic unmapped_test();
		wb_adr_t adr;
		wb_dat_t rdat;
		logic [2:0] hole;
		logic [4:0] bank;
		for (int n = 0; n < N_UNMAPPED; n++) begin
			adr = $random(seed);
			case ($random(seed) & 3)
				0: hole = 3'b000;
				1: hole = 3'b010;
				2: hole = 3'b100;
				default: hole = 3'b101;
			endcase
			adr[30:28] = hole;
			bus_write(adr, $random(seed), '1);
			bus_read(adr, rdat);
			check_value("wb_dat_o (unmapped)", 32'd0, rdat);
			bank = $random(seed);
			if (bank == SYSCTL_BANK) begin
				bank = 5'd0;
			end
			adr = csr_addr(bank, reg_ofs_t'($random(seed) & 7));
			bus_write(adr, $random(seed), '1);
			bus_read(adr, rdat);
			check_value("wb_dat_o (empty CSR bank)", 32'd0, rdat);
		end
		verify_ram();
		check_sysctl_state();
	endtask

	//--------------------------------------------------------------------
	// System controller
	//--------------------------------------------------------------------
	task automatic sysctl_test();
		wb_dat_t dat;
		wb_dat_t rdat;
		int irq_start;
		int changes;
		logic [2:0] next_btn;
		logic [3:0] next_rev;
		bus_read(csr_addr(SYSCTL_BANK, REG_SYSTEM_ID), rdat);
		check_value("system ID", 32'h12004D31, rdat);
		dat = $random(seed);
		bus_write(csr_addr(SYSCTL_BANK, REG_GPIO_OUT), dat, '1);
		led_shadow = dat[GPIO_OUT_W-1:0];
		check_sysctl_state();
		irq_start = gpio_irq_count;
		changes = 0;
		for (int n = 0; n < N_GPIO; n++) begin
			do begin
				next_btn = random_buttons();
				next_rev = $random(seed);
			end while ({next_rev, next_btn} == {pcb_rev, btn});
			@(negedge sys_clk);
			btn = next_btn;
			pcb_rev = next_rev;
			changes++;
			// Past the synchronizer before reading
			repeat (4 + ($random(seed) & 3)) @(negedge sys_clk);
			bus_read(csr_addr(SYSCTL_BANK, REG_GPIO_IN), rdat);
			check_value("GPIO input register", {25'd0, pcb_rev, btn}, rdat);
		end
		repeat (6) @(negedge sys_clk);
		check_value("gpio_irq_o pulse count", changes, gpio_irq_count - irq_start);
	endtask

	// One-shot timer, no autorestart
	task automatic timer_test();
		wb_dat_t rdat;
		int irq_start;
		int polls;
		compare_shadow = 10 + ({$random(seed)} % 191);
		bus_write(csr_addr(SYSCTL_BANK, REG_TIMER_COUNTER), 32'd0, '1);
		bus_write(csr_addr(SYSCTL_BANK, REG_TIMER_COMPARE), compare_shadow, '1);
		check_sysctl_state();
		irq_start = timer_irq_count;
		bus_write(csr_addr(SYSCTL_BANK, REG_TIMER_CTRL), 32'd1, '1);
		polls = 0;
		do begin
			bus_read(csr_addr(SYSCTL_BANK, REG_TIMER_CTRL), rdat);
			polls++;
		end while (rdat[0] !== 1'b0 && polls < TIMER_MAX);
		if (rdat[0] !== 1'b0) begin
			$display("Timer still enabled after %0d polls of the control register", polls);
			error_count++;
		end
		ctrl_shadow = 2'b00;
		repeat (2) @(negedge sys_clk);
		check_value("timer_irq_o pulse count", 32'd1, timer_irq_count - irq_start);
		bus_read(csr_addr(SYSCTL_BANK, REG_TIMER_COUNTER), rdat);
		check_value("timer counter", 32'd0, rdat);
	endtask

	//--------------------------------------------------------------------
	// Reset sources
	//--------------------------------------------------------------------
	task automatic reset_test();
		// Non-reset values so the reset is visible
		bus_write(csr_addr(SYSCTL_BANK, REG_GPIO_OUT), 32'h3, '1);
		bus_write(csr_addr(SYSCTL_BANK, REG_TIMER_CTRL), 32'h2, '1);
		@(negedge sys_clk);
		btn = 3'b111;
		wait_periph(1'b0, 8, "Three-button reset");
		btn = 3'b000;
		wait_periph(1'b1, RESET_CYCLES, "Release after three-button reset");
		check_reset_state();
		// Software hard reset
		bus_write(csr_addr(SYSCTL_BANK, REG_GPIO_OUT), 32'h1, '1);
		bus_write(csr_addr(SYSCTL_BANK, REG_HARD_RESET), 32'h1, '1);
		wait_periph(1'b0, 8, "Hard-reset register");
		wait_periph(1'b1, RESET_CYCLES, "Release after hard reset");
		check_reset_state();
		// External trigger
		bus_write(csr_addr(SYSCTL_BANK, REG_GPIO_OUT), 32'h2, '1);
		pulse_trigger_reset();
		check_reset_state();
	endtask

	//--------------------------------------------------------------------
	// Main sequence
	//--------------------------------------------------------------------
	initial begin
		seed = 92;
		trigger_reset = 1'b1;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_sel = '0;
		wb_we = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		btn = 3'b000;
		pcb_rev = 4'h0;
		led_shadow = '0;
		compare_shadow = '0;
		ctrl_shadow = 2'b00;
		pulse_trigger_reset();
		check_reset_state();
		ram_test();
		unmapped_test();
		sysctl_test();
		timer_test();
		reset_test();
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			check_count, error_count, u_soc_fabric.u_checker.fail_count);
		if (error_count == 0 && u_soc_fabric.u_checker.fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
rtl/soc_bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/soc_ifs.sv
rtl/reset_gen.sv
rtl/wb_switch.sv
rtl/wb_ram.sv
rtl/csr_bridge.sv
rtl/sysctl.sv
rtl/soc_fabric.sv
test/soc_fabric_checker.sv
test/soc_fabric_tb.sv

//--- Bender.yml
package:
  name: soc_fabric

sources:
  - rtl/soc_bus_pkg.sv
  - rtl/soc_map_pkg.sv
  - rtl/soc_ifs.sv
  - rtl/reset_gen.sv
  - rtl/wb_switch.sv
  - rtl/wb_ram.sv
  - rtl/csr_bridge.sv
  - rtl/sysctl.sv
  - rtl/soc_fabric.sv
  - target: test
    files:
      - test/soc_fabric_checker.sv
      - test/soc_fabric_tb.sv
